//--- fetch_input.txt
# M addr word : memory image, other words read as the inverted address
# F min_cycle target plv : flush, E pc inst excp(0 none 1 adef 2 priv) taken
M 1c000010 5bfff800
E 1c000000 e3ffffff 0 0
E 1c000004 e3fffffb 0 0
E 1c000008 e3fffff7 0 0
E 1c00000c e3fffff3 0 0
E 1c000010 5bfff800 0 1
E 1c000008 e3fffff7 0 0
E 1c00000c e3fffff3 0 0
E 1c000010 5bfff800 0 1
F 60 1c000104 0
E 1c000104 e3fffefb 0 0
E 1c000108 e3fffef7 0 0
E 1c00010c e3fffef3 0 0
E 1c000110 e3fffeef 0 0
E 1c000114 e3fffeeb 0 0
E 1c000118 e3fffee7 0 0
E 1c00011c e3fffee3 0 0
E 1c000120 e3fffedf 0 0
E 1c000124 e3fffedb 0 0
E 1c000128 e3fffed7 0 0
E 1c00012c e3fffed3 0 0
E 1c000130 e3fffecf 0 0
E 1c000134 e3fffecb 0 0
E 1c000138 e3fffec7 0 0
E 1c00013c e3fffec3 0 0
E 1c000140 e3fffebf 0 0
E 1c000144 e3fffebb 0 0
E 1c000148 e3fffeb7 0 0
E 1c00014c e3fffeb3 0 0
E 1c000150 e3fffeaf 0 0
F 200 1c000202 0
E 1c000202 00000000 1 0
E 1c000208 e3fffdf7 0 0
F 260 80001000 3
E 80001000 7fffefff 2 0
E 80001004 7fffeffb 2 0
E 80001008 7fffeff7 2 0

//--- list.f
fetch_pkg.sv
fetch_pc_gen.sv
fetch_predecode.sv
fetch_queue.sv
fetch_frontend_top.sv
fetch_frontend_asserts.sv
fetch_frontend_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module fetch_frontend_tb -o sim_fetch

out=$(./obj_dir/sim_fetch 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

//--- fetch_frontend_tb.sv
module fetch_frontend_tb;

    localparam int timeout_cycles = 4000;
    localparam int flush_grace    = 40;  // Cycles a flush may wait for a request in flight

    logic                     clk;
    logic                     arst_n;
    fetch_pkg::redirect_s     flush;
    fetch_pkg::plv_t          plv;
    fetch_pkg::icache_resp_s  icache_resp;
    fetch_pkg::take_t         issue_take;
    fetch_pkg::icache_req_s   icache_req;
    fetch_pkg::fetch_packet_s issue;

    logic [31:0]      mem [logic [31:0]];
    fetch_pkg::addr_t e_pc[$];
    fetch_pkg::inst_t e_inst[$];
    int               e_excp[$];
    int               e_taken[$];
    int               seg_lim[$];  // End of each expected segment in the E stream
    int               f_cyc[$];
    fetch_pkg::addr_t f_tgt[$];
    fetch_pkg::plv_t  f_plv[$];

    int               cur_seg = 0;
    int               exp_pos = 0;
    int               cyc = 0;
    int               fstate = 0;  // 0 running, 1 flush driven, 2 settling
    int               wait_cnt = 0;
    int               next_take = 0;
    logic             req_pend = 1'b0;
    fetch_pkg::addr_t req_pc;
    logic [31:0]      lfsr = 32'hbaf2;

    fetch_frontend_top uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .plv         (plv),
        .icache_resp (icache_resp),
        .issue_take  (issue_take),
        .icache_req  (icache_req),
        .issue       (issue)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic fail_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input int slot,
                                input logic [31:0] exp_v, input logic [31:0] act_v);
        $display("** Error: issue.slot[%0d].%s expected %h actual %h", slot, name, exp_v, act_v);
        fail_run();
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output int r);
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic fetch_pkg::inst_t fetch_word(input fetch_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return ~a;  // Unmapped words read back as the inverted address
    endfunction

    task automatic read_input();
        int          fd;
        int          code;
        int          c;
        int          d;
        logic [7:0]  tok;
        logic [31:0] a;
        logic [31:0] b;
        string       line;
        fd = $fopen("fetch_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the data file fetch_input.txt");
            fail_run();
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %s", tok);
                if (code != 1) begin
                    break;
                end
                case (tok)
                    "#": code = $fgets(line, fd);
                    "M": begin
                        code = $fscanf(fd, " %h %h", a, b);
                        mem[a] = b;
                    end
                    "F": begin
                        code = $fscanf(fd, " %d %h %d", c, a, d);
                        seg_lim.push_back(e_pc.size());
                        f_cyc.push_back(c);
                        f_tgt.push_back(a);
                        f_plv.push_back(fetch_pkg::plv_t'(d));
                    end
                    default: begin
                        code = $fscanf(fd, " %h %h %d %d", a, b, c, d);
                        e_pc.push_back(a);
                        e_inst.push_back(b);
                        e_excp.push_back(c);
                        e_taken.push_back(d);
                    end
                endcase
            end
            seg_lim.push_back(e_pc.size());
            $fclose(fd);
        end
    endtask

    task automatic check_entry(input fetch_pkg::fetch_entry_s e, input int slot);
        fetch_pkg::addr_t pc;
        fetch_pkg::inst_t inst;
        fetch_pkg::addr_t target;
        fetch_pkg::addr_t npc;
        fetch_pkg::plv_t  lvl;
        logic             taken;
        pc     = e_pc[exp_pos];
        inst   = e_inst[exp_pos];
        taken  = e_taken[exp_pos] != 0;
        target = pc + fetch_pkg::addr_t'(int'($signed(inst[25:10])) * 4);  // Branch offset in words
        npc    = taken ? target : pc + 32'd4;
        lvl    = (cur_seg == 0) ? fetch_pkg::plv_t'(0) : f_plv[cur_seg-1];
        assert (e.valid) else begin
            $display("Decode took slot %0d while it was not valid", slot);
            fail_run();
        end
        assert (e.pc == pc) else report_value("pc", slot, pc, e.pc);
        assert (e.inst == inst) else report_value("inst", slot, inst, e.inst);
        assert (int'(e.excp) == e_excp[exp_pos])
            else report_value("excp", slot, e_excp[exp_pos], 32'(e.excp));
        assert (e.pred.taken == taken)
            else report_value("pred.taken", slot, 32'(taken), 32'(e.pred.taken));
        assert (e.npc == npc) else report_value("npc", slot, npc, e.npc);
        assert (!taken || e.pred.target == target)
            else report_value("pred.target", slot, target, e.pred.target);
        assert (e.plv == lvl) else report_value("plv", slot, 32'(lvl), 32'(e.plv));
        exp_pos++;
    endtask

    // ------------------------------
    // Sampling, checks and decode
    // ------------------------------
    always @(negedge clk) begin
        int n;
        int want;
        int room;
        if (arst_n) begin
            if (icache_req.valid) begin
                assert (!req_pend) else begin
                    $display("A cache request was issued before the previous response");
                    fail_run();
                end
                req_pend = 1'b1;
                req_pc   = icache_req.pc;
                rand_bits(2, wait_cnt);
                wait_cnt = wait_cnt + 1;  // One to four cycles
            end
            if (issue_take > 2'd0) check_entry(issue.slot[0], 0);
            if (issue_take > 2'd1) check_entry(issue.slot[1], 1);
            // Slots still valid after the take now pending is applied
            n    = int'(issue.slot[0].valid) + int'(issue.slot[1].valid) - int'(issue_take);
            room = seg_lim[cur_seg] - exp_pos;
            rand_bits(2, want);
            if (want > 2) want = 2;
            if (cyc % 160 < 70) want = 0;  // Long decode stalls fill the queue
            if (want > n) want = n;
            if (want > room) want = room;
            if (want < 0) want = 0;
            next_take = want;
        end
    end

    // ------------------------------
    // Cache model and drive
    // ------------------------------
    always @(posedge clk) begin
        int start_fs;
        if (arst_n) begin
            cyc++;
            start_fs = fstate;
            icache_resp.valid <= 1'b0;
            if (req_pend) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    icache_resp.valid   <= 1'b1;
                    icache_resp.pc      <= req_pc;
                    icache_resp.data[0] <= fetch_word({req_pc[31:3], 3'b000});
                    icache_resp.data[1] <= fetch_word({req_pc[31:3], 3'b100});
                    req_pend = 1'b0;
                end
            end
            case (fstate)
                0: begin
                    // A request still in flight makes its response stale
                    if (exp_pos == seg_lim[cur_seg] && cur_seg < f_cyc.size()
                        && cyc >= f_cyc[cur_seg]
                        && (req_pend || cyc >= f_cyc[cur_seg] + flush_grace)) begin
                        flush.valid  <= 1'b1;
                        flush.target <= f_tgt[cur_seg];
                        plv          <= f_plv[cur_seg];
                        cur_seg++;
                        fstate = 1;
                    end
                end
                1: begin
                    flush.valid <= 1'b0;
                    fstate = 2;
                end
                default: fstate = 0;
            endcase
            issue_take <= (start_fs == 0 && fstate == 0) ? fetch_pkg::take_t'(next_take) : 2'd0;
        end
    end

    initial begin
        int waited;
        flush       <= '0;
        plv         <= '0;
        icache_resp <= '0;
        issue_take  <= '0;
        arst_n = 1'b0;
        read_input();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        waited = 0;
        while (!(cur_seg == f_cyc.size() && exp_pos == seg_lim[cur_seg])) begin
            @(posedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                $display("Timed out before the whole expected issue stream was seen");
                fail_run();
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- fetch_frontend_asserts.sv
module fetch_frontend_asserts (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     flush_valid,
    input fetch_pkg::take_t         issue_take,
    input fetch_pkg::fetch_packet_s issue,
    input fetch_pkg::qcnt_t         count
);

    logic [1:0] valid_cnt;

    assign valid_cnt = 2'(issue.slot[0].valid) + 2'(issue.slot[1].valid);

    count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        count <= fetch_pkg::qcnt_t'(fetch_pkg::queue_depth))
        else $error("Queue count above its depth");

    // Decode never takes more than it is offered
    take_bound: assert property (@(posedge clk) disable iff (!arst_n)
        issue_take <= valid_cnt)
        else $error("Decode took more entries than were valid");

    flush_empty: assert property (@(posedge clk) disable iff (!arst_n)
        flush_valid |=> (valid_cnt == 2'd0))
        else $error("Queue not empty after a flush");

endmodule

bind fetch_queue fetch_frontend_asserts u_asserts (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush_valid (flush_valid),
    .issue_take  (issue_take),
    .issue       (issue),
    .count       (count)
);

//--- fetch_frontend_top.sv
module fetch_frontend_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  fetch_pkg::redirect_s     flush,
    input  fetch_pkg::plv_t          plv,
    input  fetch_pkg::icache_resp_s  icache_resp,
    input  fetch_pkg::take_t         issue_take,
    output fetch_pkg::icache_req_s   icache_req,
    output fetch_pkg::fetch_packet_s issue
);

    fetch_pkg::redirect_s     pred_redirect;
    fetch_pkg::fetch_packet_s packet;
    fetch_pkg::qcnt_t         free_cnt;
    fetch_pkg::icache_resp_s  resp_gated;
    logic                     resp_accept;

    // Stale responses never reach the predecoder
    always_comb begin
        resp_gated       = icache_resp;
        resp_gated.valid = icache_resp.valid & resp_accept;
    end

    fetch_pc_gen u_pc_gen (
        .clk               (clk),
        .arst_n            (arst_n),
        .flush             (flush),
        .pred_redirect     (pred_redirect),
        .icache_resp_valid (icache_resp.valid),
        .free_cnt          (free_cnt),
        .icache_req        (icache_req),
        .resp_accept       (resp_accept)
    );

    fetch_predecode u_predecode (
        .icache_resp   (resp_gated),
        .plv           (plv),
        .packet        (packet),
        .pred_redirect (pred_redirect)
    );

    fetch_queue u_queue (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush_valid (flush.valid),
        .packet      (packet),
        .issue_take  (issue_take),
        .issue       (issue),
        .free_cnt    (free_cnt)
    );

endmodule

//--- fetch_queue.sv
module fetch_queue (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush_valid,
    input  fetch_pkg::fetch_packet_s packet,
    input  fetch_pkg::take_t         issue_take,
    output fetch_pkg::fetch_packet_s issue,
    output fetch_pkg::qcnt_t         free_cnt
);

    typedef logic [fetch_pkg::queue_ptr_w-1:0] ptr_t;

    fetch_pkg::fetch_entry_s entries [fetch_pkg::queue_depth];

    ptr_t             head;
    ptr_t             tail;
    ptr_t             head_p1;
    ptr_t             tail_p1;
    ptr_t             head_next;
    ptr_t             tail_next;
    fetch_pkg::qcnt_t count;
    fetch_pkg::qcnt_t count_next;
    fetch_pkg::qcnt_t enq_cnt;
    fetch_pkg::qcnt_t deq_cnt;
    logic             wr0;
    logic             wr1;

    // ------------------------------
    // Enqueue and dequeue decode
    // ------------------------------
    always_comb begin
        wr0     = packet.slot[0].valid;
        wr1     = packet.slot[1].valid;
        enq_cnt = fetch_pkg::qcnt_t'(wr0) + fetch_pkg::qcnt_t'(wr1);
        deq_cnt = fetch_pkg::qcnt_t'(issue_take);
    end

    assign head_p1 = head + ptr_t'(1);  // Pointers wrap at the queue depth
    assign tail_p1 = tail + ptr_t'(1);

    always_comb begin
        head_next  = head + ptr_t'(issue_take);
        tail_next  = tail + ptr_t'(enq_cnt);
        count_next = count + enq_cnt - deq_cnt;
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_valid) begin
            head  <= '0;  // Flush wins over any enqueue or dequeue this cycle
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head_next;
            tail  <= tail_next;
            count <= count_next;
        end
    end

    // ------------------------------
    // Entry storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (wr0) begin
            entries[tail] <= packet.slot[0];
        end
        if (wr1) begin
            entries[tail_p1] <= packet.slot[1];  // Slot 1 only comes with slot 0
        end
    end

    // ------------------------------
    // Issue side
    // ------------------------------
    always_comb begin
        issue.slot[0]       = entries[head];
        issue.slot[1]       = entries[head_p1];
        issue.slot[0].valid = count != '0;
        issue.slot[1].valid = count > fetch_pkg::qcnt_t'(1);
    end

    assign free_cnt = fetch_pkg::qcnt_t'(fetch_pkg::queue_depth) - count;

endmodule

//--- fetch_predecode.sv
module fetch_predecode (
    input  fetch_pkg::icache_resp_s  icache_resp,
    input  fetch_pkg::plv_t          plv,
    output fetch_pkg::fetch_packet_s packet,
    output fetch_pkg::redirect_s     pred_redirect
);

    // Backward direct branches are predicted taken, forward ones not taken
    function automatic fetch_pkg::pred_s predict(
        input fetch_pkg::inst_t word,
        input fetch_pkg::addr_t pc
    );
        fetch_pkg::pred_s p;
        fetch_pkg::addr_t offs;
        offs     = {{14{word[25]}}, word[25:10], 2'b00};
        p.taken  = (word[31:26] == fetch_pkg::branch_opcode) && word[25];
        p.target = pc + offs;
        return p;
    endfunction

    function automatic fetch_pkg::fetch_entry_s make_entry(
        input logic             valid,
        input fetch_pkg::addr_t pc,
        input fetch_pkg::inst_t word,
        input fetch_pkg::pred_s pred,
        input fetch_pkg::excp_e excp,
        input fetch_pkg::plv_t  plv
    );
        fetch_pkg::fetch_entry_s e;
        e.valid = valid;
        e.pc    = pc;
        e.npc   = pred.taken ? pred.target : pc + fetch_pkg::addr_t'(4);
        e.inst  = word;
        e.pred  = pred;
        e.excp  = excp;
        e.plv   = plv;
        return e;
    endfunction

    logic             misaligned;
    logic             priv;
    logic             hi_only;
    logic             v0;
    logic             v1;
    fetch_pkg::excp_e excp;
    fetch_pkg::addr_t pc1;
    fetch_pkg::inst_t word0;
    fetch_pkg::pred_s pred0;
    fetch_pkg::pred_s pred1;

    always_comb begin
        misaligned = icache_resp.pc[1:0] != 2'b00;
        priv       = icache_resp.pc[fetch_pkg::kernel_base_bit] && (plv == 2'd3);
        hi_only    = icache_resp.pc[2];  // Entered at the high word of the group

        if (misaligned) begin
            excp = fetch_pkg::EXCP_ADEF;
        end else if (priv) begin
            excp = fetch_pkg::EXCP_PRIV;
        end else begin
            excp = fetch_pkg::EXCP_NONE;
        end

        pc1   = {icache_resp.pc[fetch_pkg::addr_w-1:3], 3'b100};
        word0 = misaligned ? '0 : (hi_only ? icache_resp.data[1] : icache_resp.data[0]);

        pred0 = predict(word0, icache_resp.pc);
        pred1 = predict(icache_resp.data[1], pc1);
        if (excp != fetch_pkg::EXCP_NONE) begin
            pred0.taken = 1'b0;  // A faulting fetch never steers the PC
            pred1.taken = 1'b0;
        end

        v0 = icache_resp.valid;
        v1 = icache_resp.valid && !hi_only && !misaligned && !pred0.taken;

        packet.slot[0] = make_entry(v0, icache_resp.pc, word0, pred0, excp, plv);
        packet.slot[1] = make_entry(v1, pc1, icache_resp.data[1], pred1, excp, plv);

        // The youngest valid slot decides the redirect
        pred_redirect.valid  = v1 ? pred1.taken : (v0 && pred0.taken);
        pred_redirect.target = v1 ? pred1.target : pred0.target;
    end

endmodule

//--- fetch_pc_gen.sv
module fetch_pc_gen (
    input  logic                   clk,
    input  logic                   arst_n,
    input  fetch_pkg::redirect_s   flush,
    input  fetch_pkg::redirect_s   pred_redirect,
    input  logic                   icache_resp_valid,
    input  fetch_pkg::qcnt_t       free_cnt,
    output fetch_pkg::icache_req_s icache_req,
    output logic                   resp_accept
);

    fetch_pkg::pc_state_e state;
    fetch_pkg::addr_t     pc;
    fetch_pkg::addr_t     seq_pc;
    logic                 stale;
    logic                 room_ok;

    // Next aligned group, also realigns a misaligned flush target
    assign seq_pc  = (pc + fetch_pkg::addr_t'(8)) & ~fetch_pkg::addr_t'(7);
    assign room_ok = free_cnt >= fetch_pkg::qcnt_t'(fetch_pkg::req_room);

    assign resp_accept = (state == fetch_pkg::PC_WAIT) && !stale;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= fetch_pkg::PC_IDLE;
            pc         <= fetch_pkg::reset_pc;
            stale      <= 1'b0;
            icache_req <= '0;
        end else begin
            icache_req.valid <= 1'b0;  // Requests are single cycle pulses
            case (state)
                fetch_pkg::PC_IDLE: begin
                    if (flush.valid) begin
                        pc <= flush.target;
                    end else if (room_ok) begin
                        icache_req.valid <= 1'b1;
                        icache_req.pc    <= pc;
                        state            <= fetch_pkg::PC_WAIT;
                    end
                end
                fetch_pkg::PC_WAIT: begin
                    if (icache_resp_valid) begin
                        state <= fetch_pkg::PC_IDLE;
                        stale <= 1'b0;
                        if (flush.valid) begin
                            pc <= flush.target;
                        end else if (!stale) begin
                            pc <= pred_redirect.valid ? pred_redirect.target : seq_pc;
                        end
                    end else if (flush.valid) begin
                        pc    <= flush.target;
                        stale <= 1'b1;  // The response in flight belongs to the old path
                    end
                end
                default: state <= fetch_pkg::PC_IDLE;
            endcase
        end
    end

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

    // ------------------------------
    // Widths and constants
    // ------------------------------
    localparam int addr_w          = 32;
    localparam int inst_w          = 32;
    localparam int queue_depth     = 16;
    localparam int queue_ptr_w     = 4;
    localparam int queue_cnt_w     = 5;
    localparam int req_room        = 4;  // Free entries needed before a new request
    localparam int kernel_base_bit = 31;

    localparam logic [5:0]        branch_opcode = 6'b010110;
    localparam logic [addr_w-1:0] reset_pc      = 32'h1c000000;

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [addr_w-1:0]      addr_t;
    typedef logic [inst_w-1:0]      inst_t;
    typedef logic [1:0]             plv_t;
    typedef logic [queue_cnt_w-1:0] qcnt_t;
    typedef logic [1:0]             take_t;

    typedef enum logic [1:0] {
        EXCP_NONE,
        EXCP_ADEF,  // Fetch address not word aligned
        EXCP_PRIV   // User level fetch from the kernel half
    } excp_e;

    typedef enum logic {
        PC_IDLE,
        PC_WAIT
    } pc_state_e;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } icache_req_s;

    typedef struct packed {
        logic        valid;
        addr_t       pc;
        inst_t [1:0] data;  // Index 0 is the word at the lower address
    } icache_resp_s;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } pred_s;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t npc;
        inst_t inst;
        pred_s pred;
        excp_e excp;
        plv_t  plv;
    } fetch_entry_s;

    typedef struct packed {
        fetch_entry_s [1:0] slot;  // Slot 0 is the older instruction
    } fetch_packet_s;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_s;

endpackage
